/* filelist.f */
+incdir+test
hw/fc_cfg_pkg.sv
hw/fc_types_pkg.sv
hw/vector_mem.sv
hw/fc_ctrl.sv
hw/pe_feeder.sv
hw/mac_pe.sv
hw/result_drain.sv
hw/fc_top.sv
test/fc_tb.sv

/* hw/fc_cfg_pkg.sv */
/*
  fully connected layer engine, sizing constants
  defaults for the top level parameters, shared with the testbench
*/

package fc_cfg_pkg;

  ////////////////////////////////////////
  // stream and storage
  ////////////////////////////////////////
  parameter int DATA_W = 32;  // stream and memory word
  parameter int LANES  = 4;   // signed bytes per word
  parameter int ADDR_W = 6;   // 64 words, 256 features max

  ////////////////////////////////////////
  // compute array
  ////////////////////////////////////////
  parameter int NUM_PE     = 4;   // one per output neuron
  parameter int ACC_W      = 28;  // dot product accumulator
  parameter int MUL_STAGES = 3;   // multiplier pipeline depth, at least 3

  // requantisation of the biased sum down to a byte
  parameter int OUT_SHIFT = 6;

endpackage

/* hw/fc_ctrl.sv */
/*
  fc engine controller
  decodes start/cmd, steers incoming stream beats into the feature
  store, the weight banks or the bias register, and sequences a run
  until its result beat has been taken
*/

`timescale 1ns/10ps

module fc_ctrl import fc_types_pkg::*; #(
  parameter int ADDR_W = 6,
  parameter int NUM_PE = 4
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  input  cmd_t              cmd,
  input  logic [ADDR_W:0]   len,
  input  logic              s_valid,
  input  lane_word_t        s_data,
  input  logic              result_taken,
  output logic              s_ready,
  output logic              busy,
  output logic              done,
  output logic [ADDR_W-1:0] wr_addr,
  output lane_word_t        wr_data,
  output logic              feat_we,
  output logic [NUM_PE-1:0] weight_we,
  output logic              bias_we,
  output logic              run_go,
  output logic [ADDR_W:0]   run_len
);

  localparam int ROW_W = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

  typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_RUN} state_t;

  state_t            state;
  cmd_t              cmd_q;
  logic [ADDR_W:0]   len_q;       // length of the current load
  logic [ADDR_W:0]   feat_len_q;  // length kept for runs
  logic [ADDR_W-1:0] word_cnt;
  logic [ROW_W-1:0]  row_cnt;     // weight bank being filled
  logic              beat;
  logic              last_word;
  logic              last_beat;

  assign s_ready = (state == ST_LOAD);
  assign busy    = (state != ST_IDLE);
  assign beat    = s_valid && s_ready;

  assign last_word = ({1'b0, word_cnt} == len_q - 1'b1);

  always_comb begin
    case (cmd_q)
      CMD_LOAD_BIAS:   last_beat = 1'b1;  // single beat
      CMD_LOAD_WEIGHT: last_beat = last_word && (row_cnt == NUM_PE - 1);
      default:         last_beat = last_word;
    endcase
  end

  ////////////////////////////////////////
  // write steering
  ////////////////////////////////////////
  assign wr_addr   = word_cnt;
  assign wr_data   = s_data;
  assign feat_we   = beat && (cmd_q == CMD_LOAD_FEAT);
  assign bias_we   = beat && (cmd_q == CMD_LOAD_BIAS);
  assign weight_we = (beat && (cmd_q == CMD_LOAD_WEIGHT)) ?
                     ({{(NUM_PE-1){1'b0}}, 1'b1} << row_cnt) : '0;

  assign run_len = feat_len_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= ST_IDLE;
      cmd_q      <= CMD_LOAD_FEAT;
      len_q      <= '0;
      feat_len_q <= '0;
      word_cnt   <= '0;
      row_cnt    <= '0;
      done       <= 1'b0;
      run_go     <= 1'b0;
    end else begin
      done   <= 1'b0;
      run_go <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            cmd_q    <= cmd;
            len_q    <= len;
            word_cnt <= '0;
            row_cnt  <= '0;
            if (cmd == CMD_RUN) begin
              state  <= ST_RUN;
              run_go <= 1'b1;
            end else begin
              state <= ST_LOAD;
              if (cmd == CMD_LOAD_FEAT) feat_len_q <= len;
            end
          end
        end
        ST_LOAD: begin
          if (beat) begin
            if (last_beat) begin
              state <= ST_IDLE;
              done  <= 1'b1;
            end else if (last_word) begin  // next weight row
              word_cnt <= '0;
              row_cnt  <= row_cnt + 1'b1;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        ST_RUN: begin
          if (result_taken) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* hw/fc_top.sv */
/*
  fully connected layer engine, top level
  controller, feature store, weight banks, feeder, PE chain and drain
*/

`timescale 1ns/10ps

module fc_top import fc_cfg_pkg::*, fc_types_pkg::*; #(
  parameter int DATA_W     = fc_cfg_pkg::DATA_W,
  parameter int LANES      = fc_cfg_pkg::LANES,
  parameter int NUM_PE     = fc_cfg_pkg::NUM_PE,
  parameter int ADDR_W     = fc_cfg_pkg::ADDR_W,
  parameter int ACC_W      = fc_cfg_pkg::ACC_W,
  parameter int MUL_STAGES = fc_cfg_pkg::MUL_STAGES,
  parameter int OUT_SHIFT  = fc_cfg_pkg::OUT_SHIFT
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start,
  input  cmd_t            cmd,
  input  logic [ADDR_W:0] len,
  input  logic            s_valid,
  input  lane_word_t      s_data,
  output logic            s_ready,
  output logic            m_valid,
  output lane_word_t      m_data,
  input  logic            m_ready,
  output logic            busy,
  output logic            done
);

  logic [ADDR_W-1:0]       wr_addr;
  lane_word_t              wr_data;
  logic                    feat_we;
  logic [NUM_PE-1:0]       weight_we;
  logic                    bias_we;
  logic                    run_go;
  logic [ADDR_W:0]         run_len;
  logic                    rd_en;
  logic [ADDR_W-1:0]       rd_addr;
  logic [ADDR_W-1:0]       feat_addr;
  lane_word_t              feat_word;
  lane_word_t [NUM_PE-1:0] weight_words;
  operand_t [NUM_PE-1:0]   weight_bytes;
  acc_t [NUM_PE-1:0]       acc;
  logic [NUM_PE-1:0]       acc_valid;
  logic                    result_taken;

  // PE chain, index k feeds PE k
  operand_t pe_feat [NUM_PE+1];
  logic     pe_valid [NUM_PE+1];
  logic     pe_first [NUM_PE+1];
  logic     pe_last [NUM_PE+1];

  fc_ctrl #(.ADDR_W(ADDR_W), .NUM_PE(NUM_PE)) fc_ctrl_i (
    .clk, .rstn, .start, .cmd, .len, .s_valid, .s_data, .result_taken,
    .s_ready, .busy, .done, .wr_addr, .wr_data, .feat_we, .weight_we,
    .bias_we, .run_go, .run_len
  );

  ////////////////////////////////////////
  // storage, write port wins the address
  ////////////////////////////////////////
  assign feat_addr = feat_we ? wr_addr : rd_addr;

  vector_mem #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) feat_mem_i (
    .clk, .en(rd_en | feat_we), .we(feat_we), .addr(feat_addr),
    .wdata(wr_data.raw), .rdata(feat_word)
  );

  for (genvar k = 0; k < NUM_PE; k++) begin : g_bank
    logic [ADDR_W-1:0] bank_addr;

    assign bank_addr = weight_we[k] ? wr_addr : rd_addr;

    vector_mem #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) weight_mem_i (
      .clk, .en(rd_en | weight_we[k]), .we(weight_we[k]), .addr(bank_addr),
      .wdata(wr_data.raw), .rdata(weight_words[k])
    );
  end

  pe_feeder #(.ADDR_W(ADDR_W), .NUM_PE(NUM_PE), .LANES(LANES)) pe_feeder_i (
    .clk, .rstn, .run_go, .run_len, .feat_word, .weight_words, .rd_en, .rd_addr,
    .feat_byte(pe_feat[0]), .feat_valid(pe_valid[0]), .first(pe_first[0]),
    .last(pe_last[0]), .weight_bytes
  );

  for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
    mac_pe #(.ACC_W(ACC_W), .MUL_STAGES(MUL_STAGES)) mac_pe_i (
      .clk, .rstn,
      .feat_in(pe_feat[k]), .valid_in(pe_valid[k]), .first_in(pe_first[k]),
      .last_in(pe_last[k]), .weight_in(weight_bytes[k]),
      .feat_out(pe_feat[k+1]), .valid_out(pe_valid[k+1]), .first_out(pe_first[k+1]),
      .last_out(pe_last[k+1]), .acc(acc[k]), .acc_valid(acc_valid[k])
    );
  end

  result_drain #(.ACC_W(ACC_W), .NUM_PE(NUM_PE), .OUT_SHIFT(OUT_SHIFT)) result_drain_i (
    .clk, .rstn, .bias_we, .bias_word(wr_data), .acc, .acc_valid, .m_ready,
    .m_valid, .m_data, .result_taken
  );

endmodule

/* hw/fc_types_pkg.sv */
/*
  fully connected layer engine, shared types
  command encoding, the stream word with its two views, and the
  operand and accumulator value types
*/

package fc_types_pkg;

  import fc_cfg_pkg::*;

  // command on the cmd port, sampled with start
  typedef enum logic [1:0] {
    CMD_LOAD_FEAT   = 2'd0,
    CMD_LOAD_BIAS   = 2'd1,
    CMD_LOAD_WEIGHT = 2'd2,
    CMD_RUN         = 2'd3
  } cmd_t;

  typedef logic signed [7:0] operand_t;      // one feature, weight or bias
  typedef logic signed [ACC_W-1:0] acc_t;    // running dot product

  // one stream / memory word
  // raw for storage, lane[k] for byte k (bits 8k+7:8k)
  typedef union packed {
    logic [DATA_W-1:0]    raw;
    operand_t [LANES-1:0] lane;
  } lane_word_t;

endpackage

/* hw/mac_pe.sv */
/*
  multiply-accumulate PE
  pipelined sign-magnitude 8x8 multiplier feeding an accumulator;
  feature byte and flags are forwarded to the next PE in the chain
*/

`timescale 1ns/10ps

module mac_pe import fc_types_pkg::*; #(
  parameter int ACC_W      = 28,
  parameter int MUL_STAGES = 3
) (
  input  logic     clk,
  input  logic     rstn,
  input  operand_t feat_in,
  input  logic     valid_in,
  input  logic     first_in,
  input  logic     last_in,
  input  operand_t weight_in,
  output operand_t feat_out,
  output logic     valid_out,
  output logic     first_out,
  output logic     last_out,
  output acc_t     acc,
  output logic     acc_valid
);

  logic [7:0]              a_mag;
  logic [7:0]              b_mag;
  logic [15:0]             pp [8];
  logic [15:0]             pp_q [8];
  logic [15:0]             half_q [2];
  logic [15:0]             mag;
  logic                    sign_q1;
  logic                    sign_q2;
  logic signed [15:0]      prod_q [MUL_STAGES-2];  // stage 3 plus retiming
  logic signed [15:0]      prod;
  logic [MUL_STAGES-1:0]   vld_sr;
  logic [MUL_STAGES-1:0]   first_sr;
  logic [MUL_STAGES-1:0]   last_sr;
  logic signed [ACC_W-1:0] acc_q;

  ////////////////////////////////////////
  // multiplier
  ////////////////////////////////////////
  assign a_mag = feat_in[7] ? 8'(-feat_in) : feat_in;      // -128 gives 128
  assign b_mag = weight_in[7] ? 8'(-weight_in) : weight_in;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      pp[i] = b_mag[i] ? (16'(a_mag) << i) : 16'd0;
    end
  end

  assign mag  = half_q[0] + half_q[1];
  assign prod = prod_q[MUL_STAGES-3];

  always_ff @(posedge clk) begin
    // stage 1 partial products
    pp_q    <= pp;
    sign_q1 <= feat_in[7] ^ weight_in[7];
    // stage 2 two half sums
    half_q[0] <= pp_q[0] + pp_q[1] + pp_q[2] + pp_q[3];
    half_q[1] <= pp_q[4] + pp_q[5] + pp_q[6] + pp_q[7];
    sign_q2   <= sign_q1;
    // stage 3 sign restored
    prod_q[0] <= sign_q2 ? 16'(-$signed(mag)) : $signed(mag);
    for (int i = 1; i < MUL_STAGES - 2; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  ////////////////////////////////////////
  // flags and accumulator
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_sr    <= '0;
      first_sr  <= '0;
      last_sr   <= '0;
      valid_out <= 1'b0;
      first_out <= 1'b0;
      last_out  <= 1'b0;
      acc_valid <= 1'b0;
    end else begin
      vld_sr    <= {vld_sr[MUL_STAGES-2:0], valid_in};
      first_sr  <= {first_sr[MUL_STAGES-2:0], first_in};
      last_sr   <= {last_sr[MUL_STAGES-2:0], last_in};
      valid_out <= valid_in;
      first_out <= first_in;
      last_out  <= last_in;
      acc_valid <= vld_sr[MUL_STAGES-1] && last_sr[MUL_STAGES-1];  // sum complete
    end
  end

  always_ff @(posedge clk) begin
    feat_out <= feat_in;  // systolic forward
    if (vld_sr[MUL_STAGES-1]) begin
      acc_q <= first_sr[MUL_STAGES-1] ? ACC_W'(prod) : acc_q + ACC_W'(prod);
    end
  end

  assign acc = acc_q;

endmodule

/* hw/pe_feeder.sv */
/*
  operand feeder for the PE chain
  walks the feature store and weight banks word by word, serialises
  each word into byte cycles and skews the weight bytes so that each
  one meets its feature byte at the matching PE
*/

`timescale 1ns/10ps

module pe_feeder import fc_types_pkg::*; #(
  parameter int ADDR_W = 6,
  parameter int NUM_PE = 4,
  parameter int LANES  = 4
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    run_go,
  input  logic [ADDR_W:0]         run_len,
  input  lane_word_t              feat_word,
  input  lane_word_t [NUM_PE-1:0] weight_words,
  output logic                    rd_en,
  output logic [ADDR_W-1:0]       rd_addr,
  output operand_t                feat_byte,
  output logic                    feat_valid,
  output logic                    first,
  output logic                    last,
  output operand_t [NUM_PE-1:0]   weight_bytes
);

  localparam int LANE_W = $clog2(LANES);

  logic              rd_q;      // read issued this cycle
  logic              byte_ph;   // read data is being serialised
  logic [LANE_W-1:0] lane_sel;
  logic [ADDR_W:0]   addr_q;    // next word to read
  logic [ADDR_W:0]   cur_q;     // word being serialised
  logic [ADDR_W:0]   len_q;
  logic              more_words;
  logic              last_lane;

  assign rd_en      = rd_q;
  assign rd_addr    = addr_q[ADDR_W-1:0];
  assign more_words = (addr_q != len_q);
  assign last_lane  = (lane_sel == LANE_W'(LANES - 1));

  ////////////////////////////////////////
  // read and lane sequencing
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_q       <= 1'b0;
      byte_ph    <= 1'b0;
      lane_sel   <= '0;
      addr_q     <= '0;
      cur_q      <= '0;
      len_q      <= '0;
      feat_valid <= 1'b0;
      first      <= 1'b0;
      last       <= 1'b0;
    end else begin
      // next read lands on the last byte cycle of the current word
      rd_q <= run_go || (byte_ph && (lane_sel == LANE_W'(LANES - 2)) && more_words);

      if (run_go) begin
        addr_q <= '0;
        len_q  <= run_len;
      end else if (rd_q) begin
        addr_q <= addr_q + 1'b1;
      end

      if (rd_q) begin
        byte_ph  <= 1'b1;
        lane_sel <= '0;
        cur_q    <= addr_q;
      end else if (byte_ph) begin
        lane_sel <= lane_sel + 1'b1;
        if (last_lane) byte_ph <= 1'b0;
      end

      feat_valid <= byte_ph;
      first      <= byte_ph && (cur_q == '0) && (lane_sel == '0);
      last       <= byte_ph && last_lane && (cur_q == len_q - 1'b1);
    end
  end

  always_ff @(posedge clk) begin
    feat_byte <= feat_word.lane[lane_sel];
  end

  ////////////////////////////////////////
  // weight skew, k extra stages for PE k
  ////////////////////////////////////////
  for (genvar k = 0; k < NUM_PE; k++) begin : g_skew
    operand_t sr [0:k];

    always_ff @(posedge clk) begin
      sr[0] <= weight_words[k].lane[lane_sel];
      for (int d = 1; d <= k; d++) begin
        sr[d] <= sr[d-1];
      end
    end

    assign weight_bytes[k] = sr[k];
  end

endmodule

/* hw/result_drain.sv */
/*
  result drain
  adds the per-neuron bias to each finished sum, applies ReLU and the
  requantising shift with saturation, and holds the packed result
  beat on the output stream until it is taken
*/

`timescale 1ns/10ps

module result_drain import fc_types_pkg::*; #(
  parameter int ACC_W     = 28,
  parameter int NUM_PE    = 4,
  parameter int OUT_SHIFT = 6
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              bias_we,
  input  lane_word_t        bias_word,
  input  acc_t [NUM_PE-1:0] acc,
  input  logic [NUM_PE-1:0] acc_valid,
  input  logic              m_ready,
  output logic              m_valid,
  output lane_word_t        m_data,
  output logic              result_taken
);

  lane_word_t              bias_q;
  lane_word_t              out_word;
  logic signed [ACC_W-1:0] sum_q [NUM_PE];
  logic signed [ACC_W-1:0] cur [NUM_PE];
  logic signed [ACC_W-1:0] biased [NUM_PE];

  // ReLU, then shift and clamp to 0..127
  function automatic operand_t requant(input logic signed [ACC_W-1:0] v);
    logic signed [ACC_W-1:0] sh;
    sh = v >>> OUT_SHIFT;
    if (v < 0) return '0;
    if (sh > 127) return 8'sd127;
    return operand_t'(sh[7:0]);
  endfunction

  ////////////////////////////////////////
  // bias, relu, pack
  ////////////////////////////////////////
  always_comb begin
    out_word = '0;
    for (int k = 0; k < NUM_PE; k++) begin
      cur[k]           = acc_valid[k] ? acc[k] : sum_q[k];  // last PE is live
      biased[k]        = cur[k] + ACC_W'(signed'(bias_q.lane[k]));
      out_word.lane[k] = requant(biased[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (bias_we) bias_q <= bias_word;
    for (int k = 0; k < NUM_PE; k++) begin
      if (acc_valid[k]) sum_q[k] <= acc[k];
    end
    if (acc_valid[NUM_PE-1]) m_data <= out_word;
  end

  // one beat outstanding at most
  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid <= 1'b0;
    end else if (acc_valid[NUM_PE-1]) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  assign result_taken = m_valid && m_ready;

endmodule

/* hw/vector_mem.sv */
/*
  single-port word memory
  synchronous write, registered read with one cycle latency
*/

`timescale 1ns/10ps

module vector_mem #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 6
) (
  input  logic              clk,
  input  logic              en,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  // read data holds until the next enabled access
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // old contents on a write cycle
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the fc engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fc_tb -f filelist.f -o fc_tb_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fc_tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with error"; exit 1; }
cat sim.log

grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; } || { echo "simulation passed"; exit 0; }

/* test/fc_tb_check.svh */
/*
  fc engine testbench checks
  reference model of the layer and typed compare helpers,
  included inside the testbench module
*/

`ifndef FC_TB_CHECK_SVH
`define FC_TB_CHECK_SVH

// one output byte per neuron: dot product plus bias, relu, shift, clamp
function automatic lane_word_t expect_word(input int n_words);
  lane_word_t w;
  acc_t       sum;
  acc_t       q;
  w = '0;
  for (int k = 0; k < NUM_PE; k++) begin
    sum = acc_t'(bias_v[k]);  // sign extended bias
    for (int i = 0; i < n_words * LANES; i++) begin
      sum = sum + acc_t'(feat_v[i]) * acc_t'(wt_v[k][i]);
    end
    if (sum < 0) begin
      w.lane[k] = '0;
    end else begin
      q = sum >>> OUT_SHIFT;
      w.lane[k] = (q > 127) ? 8'sd127 : operand_t'(q);
    end
  end
  return w;
endfunction

////////////////////////////////////////
// compare helpers
////////////////////////////////////////
task automatic check_word(input lane_word_t got, input lane_word_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got.raw, exp.raw);
  end
endtask

task automatic check_lane(input operand_t got, input operand_t exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
  end
endtask

`endif

/* test/fc_tb.sv */
/*
  fc engine testbench
  loads features, weights and bias over the input stream, runs the
  layer and checks each result beat against a reference model
*/

`timescale 1ns/10ps

module fc_tb import fc_cfg_pkg::*, fc_types_pkg::*; ();

  localparam int MODE_RAND    = 0;
  localparam int MODE_NEG     = 1;  // every sum below zero
  localparam int MODE_BIG     = 2;  // saturates every lane
  localparam int MODE_PATTERN = 3;
  localparam int NUM_TESTS    = 8;
  localparam int MAX_FEAT     = LANES << ADDR_W;

  typedef struct packed {
    int len;
    int mode;
    int stall;   // cycles of m_ready low
    bit gaps;    // random s_valid gaps
    bit reload;  // clear means run on stored data
  } row_t;

  localparam row_t tests [NUM_TESTS] = '{
    '{1,  MODE_RAND,    0, 1'b0, 1'b1},
    '{2,  MODE_RAND,    3, 1'b0, 1'b1},
    '{4,  MODE_NEG,     0, 1'b0, 1'b1},
    '{3,  MODE_BIG,     0, 1'b1, 1'b1},
    '{2,  MODE_PATTERN, 2, 1'b0, 1'b1},
    '{16, MODE_RAND,    5, 1'b1, 1'b1},
    '{16, MODE_RAND,    0, 1'b0, 1'b0},
    '{64, MODE_RAND,    1, 1'b1, 1'b1}
  };

  logic            clk = 1'b0;
  logic            rstn;
  logic            start;
  cmd_t            cmd;
  logic [ADDR_W:0] len;
  logic            s_valid;
  lane_word_t      s_data;
  logic            s_ready;
  logic            m_valid;
  lane_word_t      m_data;
  logic            m_ready;
  logic            busy;
  logic            done;

  operand_t   feat_v [MAX_FEAT];
  operand_t   wt_v [NUM_PE][MAX_FEAT];
  operand_t   bias_v [NUM_PE];
  lane_word_t beats [$];
  lane_word_t last_word_q;  // previous result, for the repeat run
  int         feat_len;
  int         errors;
  int         cycle_cnt;
  int         cycle_limit;

  `include "fc_tb_check.svh"

  fc_top fc_top_i (
    .clk, .rstn, .start, .cmd, .len, .s_valid, .s_data, .s_ready,
    .m_valid, .m_data, .m_ready, .busy, .done
  );

  always #20 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("run timed out after %0d cycles without a result", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  function automatic int timeout_cycles();
    int sum;
    sum = 200;
    for (int t = 0; t < NUM_TESTS; t++) begin
      sum += (NUM_PE + 2) * tests[t].len * LANES + tests[t].stall;
    end
    return sum;
  endfunction

  function automatic operand_t pick_value(input int mode, input int role, input int k,
                                          input int i);
    int v;
    case (mode)
      MODE_NEG: begin
        v = int'($urandom_range(127, 1));
        return operand_t'((role == 0) ? v : -v);  // weights and bias negative
      end
      MODE_BIG:     return operand_t'($urandom_range(127, 100));
      MODE_PATTERN: begin
        if (role == 0) return operand_t'(i % 5 + 1);
        if (role == 1) return operand_t'((3 * k + i) % 9 + 1);
        return operand_t'(10 * k - 7);
      end
      default:      return operand_t'($urandom);
    endcase
  endfunction

  task automatic fill_vectors(input int mode, input int n_words);
    for (int i = 0; i < n_words * LANES; i++) begin
      feat_v[i] = pick_value(mode, 0, 0, i);
      for (int k = 0; k < NUM_PE; k++) wt_v[k][i] = pick_value(mode, 1, k, i);
    end
    for (int k = 0; k < NUM_PE; k++) bias_v[k] = pick_value(mode, 2, k, 0);
  endtask

  // stream words for one load command
  task automatic pack_beats(input cmd_t c);
    lane_word_t w;
    beats.delete();
    if (c == CMD_LOAD_BIAS) begin
      for (int k = 0; k < NUM_PE; k++) w.lane[k] = bias_v[k];
      beats.push_back(w);
    end else begin
      for (int k = 0; k < ((c == CMD_LOAD_WEIGHT) ? NUM_PE : 1); k++) begin
        for (int n = 0; n < feat_len; n++) begin
          for (int l = 0; l < LANES; l++) begin
            w.lane[l] = (c == CMD_LOAD_WEIGHT) ? wt_v[k][n*LANES+l] : feat_v[n*LANES+l];
          end
          beats.push_back(w);
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // bus drivers
  ////////////////////////////////////////
  task automatic issue_cmd(input cmd_t c, input int n);
    @(posedge clk);
    start <= 1'b1;
    cmd   <= c;
    len   <= (ADDR_W+1)'(n);
    @(posedge clk);
    start <= 1'b0;
  endtask

  // a second start in the middle of a load must do nothing
  task automatic poke_start_while_busy();
    @(negedge clk);
    check_flag(busy, 1'b1, "busy during load");
    @(posedge clk);
    start <= 1'b1;
    cmd   <= CMD_RUN;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic send_beats(input bit gaps);
    int i;
    i = 0;
    while (i < beats.size()) begin
      @(posedge clk);
      if (gaps && ($urandom_range(2, 0) == 0)) begin
        s_valid <= 1'b0;
      end else begin
        s_valid <= 1'b1;
        s_data  <= beats[i];
      end
      @(negedge clk);
      if (s_valid && s_ready) i++;  // taken on the coming edge
    end
    @(posedge clk);
    s_valid <= 1'b0;
  endtask

  task automatic load_beats(input cmd_t c, input int n_words, input bit gaps);
    pack_beats(c);
    issue_cmd(c, n_words);
    if (gaps) poke_start_while_busy();
    send_beats(gaps);
    do @(negedge clk); while (!done);
    check_flag(busy, 1'b0, $sformatf("busy after %s", c.name()));
  endtask

  task automatic run_and_collect(input int stall, output lane_word_t got);
    lane_word_t held;
    issue_cmd(CMD_RUN, feat_len);
    do @(negedge clk); while (!m_valid);
    held = m_data;
    repeat (stall) begin
      @(negedge clk);
      check_flag(m_valid, 1'b1, "m_valid under back-pressure");
      check_word(m_data, held, "m_data under back-pressure");
      check_flag(done, 1'b0, "done before result taken");
    end
    @(posedge clk);
    m_ready <= 1'b1;
    @(negedge clk);
    check_flag(m_valid, 1'b1, "m_valid at acceptance");
    check_word(m_data, held, "m_data at acceptance");
    @(posedge clk);
    m_ready <= 1'b0;
    @(negedge clk);
    check_flag(done, 1'b1, "done after result taken");
    check_flag(busy, 1'b0, "busy after result taken");
    check_flag(m_valid, 1'b0, "m_valid after result taken");
    got = held;
  endtask

  ////////////////////////////////////////
  // one row of the stimulus table
  ////////////////////////////////////////
  task automatic run_test(input int t);
    row_t       row;
    int         err_before;
    lane_word_t exp_w;
    lane_word_t got;
    lane_word_t sat;
    row        = tests[t];
    err_before = errors;
    sat.raw    = {LANES{8'h7f}};
    if (row.reload) begin
      fill_vectors(row.mode, row.len);
      feat_len = row.len;
      load_beats(CMD_LOAD_FEAT, feat_len, row.gaps);
      load_beats(CMD_LOAD_WEIGHT, feat_len, row.gaps);
      load_beats(CMD_LOAD_BIAS, 1, row.gaps);
    end
    exp_w = expect_word(feat_len);
    run_and_collect(row.stall, got);
    for (int k = 0; k < NUM_PE; k++) begin
      check_lane(got.lane[k], exp_w.lane[k], $sformatf("test %0d neuron %0d", t, k));
    end
    if (row.mode == MODE_NEG) check_word(got, '0, "relu on negative sums");
    if (row.mode == MODE_BIG) check_word(got, sat, "saturation at 127");
    if (!row.reload) check_word(got, last_word_q, "repeat run without reload");
    last_word_q = got;
    $display("test %0d len %0d mode %0d stall %0d: %s", t, feat_len, row.mode, row.stall,
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    cycle_limit = timeout_cycles();
    errors      = 0;
    cycle_cnt   = 0;
    feat_len    = 0;
    void'($urandom(76113));
    rstn    <= 1'b0;
    start   <= 1'b0;
    cmd     <= CMD_LOAD_FEAT;
    len     <= '0;
    s_valid <= 1'b0;
    s_data  <= '0;
    m_ready <= 1'b0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_flag(s_ready, 1'b0, "s_ready after reset");
    check_flag(m_valid, 1'b0, "m_valid after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(done, 1'b0, "done after reset");

    for (int t = 0; t < NUM_TESTS; t++) run_test(t);

    $display("%0d tests run, %0d checks failed", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
